// File: verilog/bpred_defs.svh
`ifndef BPRED_DEFS_SVH
`define BPRED_DEFS_SVH

// Address and data path width
`define XLEN 32

// Direct-mapped BTB geometry
// Index comes from PC bits above bit 1
`define BTB_ENTRIES 16
`define BTB_IDX_W 4

// Return address stack geometry
`define RAS_DEPTH 4
`define RAS_PTR_W 2

// Build-time switches
// With prediction off nothing is ever flagged as mispredicted
`define BPRED_ENABLE 1

// Without the RAS every JALR redirects
`define RAS_ENABLE 1

`endif

// File: verilog/bpred_state_pkg.sv
`default_nettype none

package bpred_state_pkg;

  // 2-bit saturating direction counter
  typedef enum logic [1:0] {
    strong_nt = 2'd0,
    weak_nt   = 2'd1,
    weak_t    = 2'd2,
    strong_t  = 2'd3
  } ctr_e;

  // Taken from weak_t upward
  function automatic logic ctr_taken(input ctr_e c);
    return (c == weak_t) || (c == strong_t);
  endfunction

  // Step towards taken or not taken, saturating at both ends
  function automatic ctr_e ctr_next(input ctr_e c, input logic taken);
    case (c)
      strong_nt: return taken ? weak_nt : strong_nt;
      weak_nt:   return taken ? weak_t : strong_nt;
      weak_t:    return taken ? strong_t : weak_nt;
      default:   return taken ? strong_t : weak_t;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: verilog/bpred_ctrl_pkg.sv
`default_nettype none

package bpred_ctrl_pkg;

  // Control-flow kind of an instruction
  // cf_call is a JAL or JALR writing the link register
  // cf_ret is a JALR through the link register
  typedef enum logic [2:0] {
    cf_none   = 3'd0,
    cf_branch = 3'd1,
    cf_jal    = 3'd2,
    cf_call   = 3'd3,
    cf_ret    = 3'd4,
    cf_jalr   = 3'd5
  } cf_kind_e;

  // Unconditional jumps of any flavour
  function automatic logic cf_is_jump(input cf_kind_e k);
    return (k == cf_jal) || (k == cf_call) || (k == cf_ret) || (k == cf_jalr);
  endfunction

  // Register-indirect jumps checked in MEM
  function automatic logic cf_is_jalr(input cf_kind_e k);
    return (k == cf_ret) || (k == cf_jalr);
  endfunction

endpackage

`default_nettype wire

// File: verilog/bpred_btb.sv
`default_nettype none

`include "bpred_defs.svh"

module bpred_btb (
  input  wire logic                    clk,
  input  wire logic                    rst_n,

  // Fetch side lookup
  input  wire logic [`XLEN-1:0]        lookup_pc,

  // Update from the resolve path
  input  wire logic                    upd_valid,
  input  wire logic [`XLEN-1:0]        upd_pc,
  input  wire bpred_ctrl_pkg::cf_kind_e upd_kind,
  input  wire logic                    upd_taken,
  input  wire logic [`XLEN-1:0]        upd_target,

  // Lookup result
  output logic                         hit,
  output bpred_ctrl_pkg::cf_kind_e     hit_kind,
  output logic                         hit_taken,
  output logic [`XLEN-1:0]             hit_target
);

  // Entry storage with one slot per index
  logic                     entry_valid  [`BTB_ENTRIES];
  logic [`XLEN-1:0]         entry_tag    [`BTB_ENTRIES];
  bpred_ctrl_pkg::cf_kind_e entry_kind   [`BTB_ENTRIES];
  logic [`XLEN-1:0]         entry_target [`BTB_ENTRIES];
  bpred_state_pkg::ctr_e    entry_ctr    [`BTB_ENTRIES];

  logic [`BTB_IDX_W-1:0] lookup_idx;
  logic [`BTB_IDX_W-1:0] upd_idx;

  logic upd_match;
  logic upd_eff_taken;
  logic upd_alloc;
  logic upd_train;

  // Word-aligned PCs skip bits 1:0
  assign lookup_idx = lookup_pc[`BTB_IDX_W+1:2];
  assign upd_idx    = upd_pc[`BTB_IDX_W+1:2];

  // Full PC compare as tag
  assign hit = entry_valid[lookup_idx] && (entry_tag[lookup_idx] == lookup_pc);

  // Kind reads as cf_none on a miss
  assign hit_kind   = hit ? entry_kind[lookup_idx] : bpred_ctrl_pkg::cf_none;
  assign hit_taken  = hit && bpred_state_pkg::ctr_taken(entry_ctr[lookup_idx]);
  assign hit_target = entry_target[lookup_idx];

  // Jumps always train as taken
  assign upd_eff_taken = upd_taken || bpred_ctrl_pkg::cf_is_jump(upd_kind);

  // Slot already owned by this PC
  assign upd_match = entry_valid[upd_idx] && (entry_tag[upd_idx] == upd_pc);

  // New entries only come from taken results
  assign upd_alloc = upd_valid && !upd_match && upd_eff_taken;
  assign upd_train = upd_valid && upd_match;

  // Valid bit per entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `BTB_ENTRIES; i++) begin
        entry_valid[i] <= 1'b0;
      end
    end else if (upd_alloc) begin
      entry_valid[upd_idx] <= 1'b1;
    end
  end

  // Payload and counters
  always_ff @(posedge clk) begin
    if (upd_alloc) begin
      entry_tag[upd_idx]    <= upd_pc;
      entry_kind[upd_idx]   <= upd_kind;
      entry_target[upd_idx] <= upd_target;
      // Fresh entries start just over the taken threshold
      entry_ctr[upd_idx]    <= bpred_state_pkg::weak_t;
    end else if (upd_train) begin
      entry_kind[upd_idx] <= upd_kind;
      entry_ctr[upd_idx]  <= bpred_state_pkg::ctr_next(entry_ctr[upd_idx], upd_eff_taken);
      // Keep the last taken target
      // A not-taken result only carries the fall-through
      if (upd_eff_taken) begin
        entry_target[upd_idx] <= upd_target;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/bpred_ras.sv
`default_nettype none

`include "bpred_defs.svh"

module bpred_ras (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             push,
  input  wire logic [`XLEN-1:0] push_addr,
  input  wire logic             pop,
  output logic                  top_valid,
  output logic [`XLEN-1:0]      top_addr
);

  // Count saturates here, older entries get overwritten
  localparam logic [`RAS_PTR_W:0] FULL_CNT = `RAS_DEPTH;

  logic [`XLEN-1:0]     stack [`RAS_DEPTH];
  logic [`RAS_PTR_W-1:0] top_ptr;
  logic [`RAS_PTR_W:0]   count;

  logic pop_eff;

  // Popping an empty stack does nothing
  assign pop_eff = pop && (count != '0);

  assign top_valid = (count != '0);
  assign top_addr  = stack[top_ptr];

  // Pointer and count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      top_ptr <= '0;
      count   <= '0;
    end else if (push && !pop_eff) begin
      // Pointer wraps, so a full stack drops its oldest entry
      top_ptr <= top_ptr + 1'b1;
      if (count != FULL_CNT) begin
        count <= count + 1'b1;
      end
    end else if (pop_eff && !push) begin
      top_ptr <= top_ptr - 1'b1;
      count   <= count - 1'b1;
    end
  end

  // Entry writes
  always_ff @(posedge clk) begin
    if (push && pop_eff) begin
      // Push and pop together swap the top entry
      stack[top_ptr] <= push_addr;
    end else if (push) begin
      stack[top_ptr + 1'b1] <= push_addr;
    end
  end

endmodule

`default_nettype wire

// File: verilog/bpred_mispred_mem.sv
`default_nettype none

`include "bpred_defs.svh"

module bpred_mispred_mem (
  // Registered branch and JALR results in MEM
  input  wire logic             is_branch_mem,
  input  wire logic             branch_taken_mem,
  input  wire logic             is_jalr_mem,
  input  wire logic             bpred_taken_mem,
  input  wire logic [`XLEN-1:0] jb_tgt_mem,
  input  wire logic [`XLEN-1:0] pred_tgt_mem,

  output logic                  branch_mispredicted_mem,
  output logic                  jalr_mispredicted_mem
);

  // Branch check, direction only
  if (`BPRED_ENABLE != 0) begin : g_branch_mispred
    assign branch_mispredicted_mem = is_branch_mem &&
        (branch_taken_mem != bpred_taken_mem);
  end else begin : g_no_branch_mispred
    assign branch_mispredicted_mem = 1'b0;
  end

  // JALR check needs both direction and target
  if (`BPRED_ENABLE != 0 && `RAS_ENABLE != 0) begin : g_jalr_mispred
    // Unpredicted, or RAS target wrong
    assign jalr_mispredicted_mem = is_jalr_mem &&
        (!bpred_taken_mem || (pred_tgt_mem != jb_tgt_mem));
  end else if (`BPRED_ENABLE != 0) begin : g_jalr_no_ras
    // No target source for JALR, so always redirect
    assign jalr_mispredicted_mem = is_jalr_mem;
  end else begin : g_no_jalr_mispred
    assign jalr_mispredicted_mem = 1'b0;
  end

endmodule

`default_nettype wire

// File: verilog/bpred_resolve.sv
`default_nettype none

`include "bpred_defs.svh"

module bpred_resolve (
  input  wire logic                     clk,
  input  wire logic                     rst_n,

  // Resolution from EX
  input  wire logic                     ex_valid,
  input  wire logic [`XLEN-1:0]         ex_pc,
  input  wire bpred_ctrl_pkg::cf_kind_e ex_kind,
  input  wire logic                     ex_taken,
  input  wire logic [`XLEN-1:0]         ex_target,
  input  wire logic                     ex_pred_taken,
  input  wire logic [`XLEN-1:0]         ex_pred_target,

  // Front end redirect
  output logic                          redirect_valid,
  output logic [`XLEN-1:0]              redirect_pc,

  // BTB training
  output logic                          upd_valid,
  output logic [`XLEN-1:0]              upd_pc,
  output bpred_ctrl_pkg::cf_kind_e      upd_kind,
  output logic                          upd_taken,
  output logic [`XLEN-1:0]              upd_target
);

  // MEM stage copy of the EX group
  logic                     mem_valid;
  logic [`XLEN-1:0]         mem_pc;
  bpred_ctrl_pkg::cf_kind_e mem_kind;
  logic                     mem_taken;
  logic [`XLEN-1:0]         mem_target;
  logic                     mem_pred_taken;
  logic [`XLEN-1:0]         mem_pred_target;

  logic is_branch_mem;
  logic is_jalr_mem;
  logic branch_mispredicted;
  logic jalr_mispredicted;

  // Wrong-path EX result is dropped while redirecting
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_valid <= 1'b0;
    end else begin
      mem_valid <= ex_valid && !redirect_valid;
    end
  end

  // Payload copied from EX every cycle and qualified by mem_valid
  always_ff @(posedge clk) begin
    mem_pc          <= ex_pc;
    mem_kind        <= ex_kind;
    mem_taken       <= ex_taken;
    mem_target      <= ex_target;
    mem_pred_taken  <= ex_pred_taken;
    mem_pred_target <= ex_pred_target;
  end

  assign is_branch_mem = mem_valid && (mem_kind == bpred_ctrl_pkg::cf_branch);

  // Returns and plain JALRs
  // JAL is fixed up in decode
  assign is_jalr_mem = mem_valid && bpred_ctrl_pkg::cf_is_jalr(mem_kind);

  bpred_mispred_mem bpred_mispred_mem_inst (
    .is_branch_mem           (is_branch_mem),
    .branch_taken_mem        (mem_taken),
    .is_jalr_mem             (is_jalr_mem),
    .bpred_taken_mem         (mem_pred_taken),
    .jb_tgt_mem              (mem_target),
    .pred_tgt_mem            (mem_pred_target),
    .branch_mispredicted_mem (branch_mispredicted),
    .jalr_mispredicted_mem   (jalr_mispredicted)
  );

  assign redirect_valid = branch_mispredicted || jalr_mispredicted;

  // Actual target if taken and fall-through otherwise
  assign redirect_pc = mem_taken ? mem_target : (mem_pc + `XLEN'd4);

  // Every resolved branch or jump trains the BTB
  assign upd_valid  = mem_valid && (mem_kind != bpred_ctrl_pkg::cf_none);
  assign upd_pc     = mem_pc;
  assign upd_kind   = mem_kind;
  assign upd_taken  = mem_taken;
  assign upd_target = mem_target;

endmodule

`default_nettype wire

// File: verilog/bpred_top.sv
`default_nettype none

`include "bpred_defs.svh"

module bpred_top (
  input  wire logic                     clk,
  input  wire logic                     rst_n,

  // Fetch request
  input  wire logic                     fetch_valid,
  input  wire logic [`XLEN-1:0]         fetch_pc,

  // EX resolution
  input  wire logic                     ex_valid,
  input  wire logic [`XLEN-1:0]         ex_pc,
  input  wire bpred_ctrl_pkg::cf_kind_e ex_kind,
  input  wire logic                     ex_taken,
  input  wire logic [`XLEN-1:0]         ex_target,
  input  wire logic                     ex_pred_taken,
  input  wire logic [`XLEN-1:0]         ex_pred_target,

  // Fetch prediction
  output logic                          pred_taken,
  output logic [`XLEN-1:0]              pred_target,
  output bpred_ctrl_pkg::cf_kind_e      pred_kind,

  // Redirect from MEM
  output logic                          redirect_valid,
  output logic [`XLEN-1:0]              redirect_pc
);

  logic                     btb_hit;
  bpred_ctrl_pkg::cf_kind_e btb_kind;
  logic                     btb_taken;
  logic [`XLEN-1:0]         btb_target;

  logic                     upd_valid;
  logic [`XLEN-1:0]         upd_pc;
  bpred_ctrl_pkg::cf_kind_e upd_kind;
  logic                     upd_taken;
  logic [`XLEN-1:0]         upd_target;

  logic             ras_push;
  logic             ras_pop;
  logic             ras_top_valid;
  logic [`XLEN-1:0] ras_top_addr;
  logic             fetch_is_ret;

  bpred_btb bpred_btb_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .lookup_pc  (fetch_pc),
    .upd_valid  (upd_valid),
    .upd_pc     (upd_pc),
    .upd_kind   (upd_kind),
    .upd_taken  (upd_taken),
    .upd_target (upd_target),
    .hit        (btb_hit),
    .hit_kind   (btb_kind),
    .hit_taken  (btb_taken),
    .hit_target (btb_target)
  );

  // Return seen by the BTB and served from the RAS
  assign fetch_is_ret = btb_hit && (btb_kind == bpred_ctrl_pkg::cf_ret) && (`RAS_ENABLE != 0);

  // Calls push the link address and returns pop it
  assign ras_push = fetch_valid && btb_hit && (btb_kind == bpred_ctrl_pkg::cf_call);
  assign ras_pop  = fetch_valid && fetch_is_ret;

  bpred_ras bpred_ras_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (ras_push),
    .push_addr (fetch_pc + `XLEN'd4),
    .pop       (ras_pop),
    .top_valid (ras_top_valid),
    .top_addr  (ras_top_addr)
  );

  // Empty RAS leaves a return predicted not taken
  assign pred_taken  = (`BPRED_ENABLE != 0) && btb_taken && (!fetch_is_ret || ras_top_valid);
  assign pred_target = fetch_is_ret ? ras_top_addr : btb_target;
  assign pred_kind   = btb_kind;

  bpred_resolve bpred_resolve_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid       (ex_valid),
    .ex_pc          (ex_pc),
    .ex_kind        (ex_kind),
    .ex_taken       (ex_taken),
    .ex_target      (ex_target),
    .ex_pred_taken  (ex_pred_taken),
    .ex_pred_target (ex_pred_target),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .upd_valid      (upd_valid),
    .upd_pc         (upd_pc),
    .upd_kind       (upd_kind),
    .upd_taken      (upd_taken),
    .upd_target     (upd_target)
  );

endmodule

`default_nettype wire

// File: testbench/bpred_assert.sv
`default_nettype none

`include "bpred_defs.svh"

module bpred_assert (
  input wire logic                     clk,
  input wire logic                     rst_n,
  input wire logic                     ex_valid,
  input wire logic [`XLEN-1:0]         ex_pc,
  input wire bpred_ctrl_pkg::cf_kind_e ex_kind,
  input wire logic                     ex_taken,
  input wire logic [`XLEN-1:0]         ex_target,
  input wire logic                     ex_pred_taken,
  input wire logic                     redirect_valid,
  input wire logic [`XLEN-1:0]         redirect_pc,
  input wire logic                     upd_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  // Read by the testbench for its closing report
  int unsigned fail_count = 0;

  // EX result that MEM will hold next cycle
  logic accepted;
  logic is_branch;
  logic is_jalr;

  assign accepted  = ex_valid && !redirect_valid;
  assign is_branch = (ex_kind == bpred_ctrl_pkg::cf_branch);
  assign is_jalr   = (ex_kind == bpred_ctrl_pkg::cf_ret) || (ex_kind == bpred_ctrl_pkg::cf_jalr);

  // Redirect stays quiet while in reset
  a_reset_idle: assert property (@(posedge clk) !rst_n |-> !redirect_valid)
    else begin
      fail_count = fail_count + 1;
      $error("redirect active during reset");
    end

  // Wrong direction: redirect to target if taken, else fall through
  a_branch_mispred: assert property (@(posedge clk) disable iff (!rst_n)
    accepted && is_branch && (ex_taken != ex_pred_taken) |=> redirect_valid &&
      (redirect_pc == ($past(ex_taken) ? $past(ex_target) : $past(ex_pc) + 32'd4)))
    else begin
      fail_count = fail_count + 1;
      $error("mispredicted branch gave wrong or missing redirect");
    end

  // Right direction, no redirect
  a_branch_ok: assert property (@(posedge clk) disable iff (!rst_n)
    accepted && is_branch && (ex_taken == ex_pred_taken) |=> !redirect_valid)
    else begin
      fail_count = fail_count + 1;
      $error("correctly predicted branch redirected");
    end

  // Wrong-path resolution leaves no trace in MEM
  a_flush: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid && redirect_valid |=> !redirect_valid && !upd_valid)
    else begin
      fail_count = fail_count + 1;
      $error("flushed resolution reached MEM");
    end

  // Unpredicted JALR goes to its real target
  a_jalr_unpred: assert property (@(posedge clk) disable iff (!rst_n)
    accepted && is_jalr && !ex_pred_taken |=>
      redirect_valid && (redirect_pc == $past(ex_target)))
    else begin
      fail_count = fail_count + 1;
      $error("unpredicted JALR not redirected to its target");
    end

endmodule

bind bpred_top bpred_assert bpred_assert_inst (.*);

`default_nettype wire

// File: testbench/bpred_tb.sv
`default_nettype none

`include "bpred_defs.svh"

module bpred_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // Upper estimate of the test length, limit has a wide margin
  localparam int TEST_CYCLES = 600;
  localparam int MAX_CYCLES  = TEST_CYCLES * 3 + 200;

  logic                     clk;
  logic                     rst_n;
  logic                     fetch_valid;
  logic [`XLEN-1:0]         fetch_pc;
  logic                     ex_valid;
  logic [`XLEN-1:0]         ex_pc;
  bpred_ctrl_pkg::cf_kind_e ex_kind;
  logic                     ex_taken;
  logic [`XLEN-1:0]         ex_target;
  logic                     ex_pred_taken;
  logic [`XLEN-1:0]         ex_pred_target;
  logic                     pred_taken;
  logic [`XLEN-1:0]         pred_target;
  bpred_ctrl_pkg::cf_kind_e pred_kind;
  logic                     redirect_valid;
  logic [`XLEN-1:0]         redirect_pc;

  // Reference BTB, counter 0 is strongly not taken
  logic                     m_valid  [`BTB_ENTRIES];
  logic [`XLEN-1:0]         m_tag    [`BTB_ENTRIES];
  bpred_ctrl_pkg::cf_kind_e m_kind   [`BTB_ENTRIES];
  logic [`XLEN-1:0]         m_target [`BTB_ENTRIES];
  logic [1:0]               m_ctr    [`BTB_ENTRIES];
  // Reference RAS, newest at the back
  logic [`XLEN-1:0]         m_ras [$];

  // Model prediction for the current fetch
  logic                     exp_taken;
  logic [`XLEN-1:0]         exp_target;
  bpred_ctrl_pkg::cf_kind_e exp_kind;

  logic [31:0] lfsr = 32'h5ddc_039d;
  int          checks = 0;
  int          errors = 0;
  int          cycle = 0;

  bpred_top bpred_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .ex_valid       (ex_valid),
    .ex_pc          (ex_pc),
    .ex_kind        (ex_kind),
    .ex_taken       (ex_taken),
    .ex_target      (ex_target),
    .ex_pred_taken  (ex_pred_taken),
    .ex_pred_target (ex_pred_target),
    .pred_taken     (pred_taken),
    .pred_target    (pred_target),
    .pred_kind      (pred_kind),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout: no end of test after %0d cycles", cycle);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Galois LFSR, one step per bit
  function automatic logic lfsr_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected 0x%h, actual 0x%h", name, exp, act);
    end
  endtask

  // Expected fetch prediction from the model
  task automatic predict_model(input logic [`XLEN-1:0] pc);
    logic [`BTB_IDX_W-1:0] idx;
    logic                  hit;
    logic                  is_ret;
    idx = pc[`BTB_IDX_W+1:2];
    hit = m_valid[idx] && (m_tag[idx] == pc);
    exp_kind = hit ? m_kind[idx] : bpred_ctrl_pkg::cf_none;
    is_ret = hit && (m_kind[idx] == bpred_ctrl_pkg::cf_ret);
    // Return without a stacked address is not taken
    exp_taken = hit && (m_ctr[idx] >= 2'd2) && (!is_ret || (m_ras.size() > 0));
    exp_target = (is_ret && (m_ras.size() > 0)) ? m_ras[$] : m_target[idx];
  endtask

  // BTB training as a resolution in MEM does it
  task automatic train_model(input bpred_ctrl_pkg::cf_kind_e kind, input logic [`XLEN-1:0] pc,
                             input logic taken, input logic [`XLEN-1:0] target);
    logic [`BTB_IDX_W-1:0] idx;
    logic                  eff;
    idx = pc[`BTB_IDX_W+1:2];
    // Jumps count as taken
    eff = taken || (kind != bpred_ctrl_pkg::cf_branch);
    if (kind == bpred_ctrl_pkg::cf_none) begin
      eff = 1'b0;
    end else if (m_valid[idx] && (m_tag[idx] == pc)) begin
      m_kind[idx] = kind;
      if (eff) begin
        m_target[idx] = target;
        if (m_ctr[idx] != 2'd3) m_ctr[idx] = m_ctr[idx] + 2'd1;
      end else if (m_ctr[idx] != 2'd0) begin
        m_ctr[idx] = m_ctr[idx] - 2'd1;
      end
    end else if (eff) begin
      // New entry starts weakly taken
      m_valid[idx]  = 1'b1;
      m_tag[idx]    = pc;
      m_kind[idx]   = kind;
      m_target[idx] = target;
      m_ctr[idx]    = 2'd2;
    end
  endtask

  // One fetch cycle, checked against the model
  task automatic fetch(input string name, input logic [`XLEN-1:0] pc);
    @(negedge clk);
    fetch_valid = 1'b1;
    fetch_pc    = pc;
    predict_model(pc);
    #2;
    check_value({name, " taken"}, 32'(exp_taken), 32'(pred_taken));
    check_value({name, " kind"}, 32'(exp_kind), 32'(pred_kind));
    if (exp_taken) check_value({name, " target"}, exp_target, pred_target);
    // Calls push the link address, full stack loses its oldest
    if (exp_kind == bpred_ctrl_pkg::cf_call) begin
      m_ras.push_back(pc + 32'd4);
      if (m_ras.size() > `RAS_DEPTH) void'(m_ras.pop_front());
    end else if ((exp_kind == bpred_ctrl_pkg::cf_ret) && (m_ras.size() > 0)) begin
      void'(m_ras.pop_back());
    end
  endtask

  task automatic drive_ex(input bpred_ctrl_pkg::cf_kind_e kind, input logic [`XLEN-1:0] pc,
                          input logic taken, input logic [`XLEN-1:0] target,
                          input logic p_taken, input logic [`XLEN-1:0] p_target);
    ex_valid       = 1'b1;
    ex_kind        = kind;
    ex_pc          = pc;
    ex_taken       = taken;
    ex_target      = target;
    ex_pred_taken  = p_taken;
    ex_pred_target = p_target;
  endtask

  // Resolution in EX, redirect checked one cycle later
  task automatic resolve(input string name, input bpred_ctrl_pkg::cf_kind_e kind,
                         input logic [`XLEN-1:0] pc, input logic taken,
                         input logic [`XLEN-1:0] target, input logic p_taken,
                         input logic [`XLEN-1:0] p_target);
    logic mis;
    @(negedge clk);
    fetch_valid = 1'b0;
    drive_ex(kind, pc, taken, target, p_taken, p_target);
    @(negedge clk);
    ex_valid = 1'b0;
    // Branch checks direction, JALR checks direction and target, JAL nothing
    if (kind == bpred_ctrl_pkg::cf_branch) begin
      mis = (taken != p_taken);
    end else if ((kind == bpred_ctrl_pkg::cf_ret) || (kind == bpred_ctrl_pkg::cf_jalr)) begin
      mis = !p_taken || (p_target != target);
    end else begin
      mis = 1'b0;
    end
    check_value({name, " redirect"}, 32'(mis), 32'(redirect_valid));
    if (mis) check_value({name, " redirect_pc"}, taken ? target : pc + 32'd4, redirect_pc);
    train_model(kind, pc, taken, target);
  endtask

  initial begin
    int assert_errors;
    rst_n          = 1'b0;
    fetch_valid    = 1'b0;
    fetch_pc       = '0;
    ex_valid       = 1'b0;
    ex_pc          = '0;
    ex_kind        = bpred_ctrl_pkg::cf_none;
    ex_taken       = 1'b0;
    ex_target      = '0;
    ex_pred_taken  = 1'b0;
    ex_pred_target = '0;
    for (int i = 0; i < `BTB_ENTRIES; i++) begin
      m_valid[i]  = 1'b0;
      m_tag[i]    = '0;
      m_kind[i]   = bpred_ctrl_pkg::cf_none;
      m_target[i] = '0;
      m_ctr[i]    = 2'd0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Empty predictor after reset
    check_value("reset redirect", 32'd0, 32'(redirect_valid));
    fetch("reset lookup a", 32'h0000_0100);
    fetch("reset lookup b", 32'h0000_040c);

    // Taken branch learned, then unlearned by two not-taken results
    resolve("learn taken", bpred_ctrl_pkg::cf_branch, 32'h100, 1'b1, 32'h180, 1'b0, '0);
    fetch("learn hit", 32'h0000_0100);
    resolve("learn nt 1", bpred_ctrl_pkg::cf_branch, 32'h100, 1'b0, 32'h180, exp_taken, '0);
    fetch("learn weak", 32'h0000_0100);
    resolve("learn nt 2", bpred_ctrl_pkg::cf_branch, 32'h100, 1'b0, 32'h180, exp_taken, '0);
    fetch("learn not taken", 32'h0000_0100);

    // Random directions against the counter model
    for (int i = 0; i < 48; i++) begin
      fetch("random fetch", 32'h0000_1010);
      resolve("random resolve", bpred_ctrl_pkg::cf_branch, 32'h1010, lfsr_bit(), 32'h1800,
              exp_taken, exp_target);
    end

    // Call and return pair through the RAS
    resolve("ras call train", bpred_ctrl_pkg::cf_call, 32'h208, 1'b1, 32'h400, 1'b0, '0);
    resolve("ras ret train", bpred_ctrl_pkg::cf_ret, 32'h40c, 1'b1, 32'h20c, 1'b0, '0);
    fetch("ras call", 32'h0000_0208);
    fetch("ras ret", 32'h0000_040c);
    resolve("ras ret match", bpred_ctrl_pkg::cf_ret, 32'h40c, 1'b1, 32'h20c, 1'b1, 32'h20c);
    resolve("ras ret mismatch", bpred_ctrl_pkg::cf_ret, 32'h40c, 1'b1, 32'h300, 1'b1, 32'h20c);
    // Overflow, then pops past empty
    repeat (6) fetch("ras deep call", 32'h0000_0208);
    repeat (6) fetch("ras deep ret", 32'h0000_040c);

    // Second resolution arrives while the first redirects
    @(negedge clk);
    fetch_valid = 1'b0;
    drive_ex(bpred_ctrl_pkg::cf_branch, 32'h504, 1'b1, 32'h5c0, 1'b0, '0);
    @(negedge clk);
    check_value("flush first redirect", 32'd1, 32'(redirect_valid));
    train_model(bpred_ctrl_pkg::cf_branch, 32'h504, 1'b1, 32'h5c0);
    drive_ex(bpred_ctrl_pkg::cf_branch, 32'h718, 1'b1, 32'h7e0, 1'b0, '0);
    @(negedge clk);
    ex_valid = 1'b0;
    check_value("flush dropped redirect", 32'd0, 32'(redirect_valid));
    fetch("flush no update", 32'h0000_0718);
    fetch("flush first learned", 32'h0000_0504);

    // Plain JALR, then JAL which is never checked
    resolve("jalr unpredicted", bpred_ctrl_pkg::cf_jalr, 32'h620, 1'b1, 32'h7a0, 1'b0, '0);
    resolve("jalr bad target", bpred_ctrl_pkg::cf_jalr, 32'h620, 1'b1, 32'h7c0, 1'b1, 32'h7a0);
    resolve("jalr good target", bpred_ctrl_pkg::cf_jalr, 32'h620, 1'b1, 32'h7c0, 1'b1, 32'h7c0);
    resolve("jal", bpred_ctrl_pkg::cf_jal, 32'h640, 1'b1, 32'h900, 1'b0, '0);
    fetch("jal learned", 32'h0000_0640);

    @(negedge clk);
    fetch_valid = 1'b0;
    repeat (2) @(negedge clk);
    assert_errors = int'(bpred_top_inst.bpred_assert_inst.fail_count);
    $display("Checks: %0d, model errors: %0d, assertion errors: %0d",
             checks, errors, assert_errors);
    if ((errors == 0) && (assert_errors == 0)) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+verilog
verilog/bpred_state_pkg.sv
verilog/bpred_ctrl_pkg.sv
verilog/bpred_btb.sv
verilog/bpred_ras.sv
verilog/bpred_mispred_mem.sv
verilog/bpred_resolve.sv
verilog/bpred_top.sv
testbench/bpred_assert.sv
testbench/bpred_tb.sv

// File: Makefile
# Verilator build and run of the branch predictor testbench

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module bpred_tb -Mdir obj_dir
	./obj_dir/Vbpred_tb | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
